//--- src/i2c_consts.svh
`ifndef I2C_CONSTS_SVH
`define I2C_CONSTS_SVH

// bus field widths
`define I2C_ADDR_WIDTH      7
`define I2C_BYTE_WIDTH      8

// divider value from the host
`define I2C_DIVIDER_WIDTH   16

// divider ticks in one bit operation
`define I2C_PHASES_PER_BIT  4

// commands the host may have outstanding
`define I2C_HOST_CREDITS    1

`endif

//--- src/i2c_bus_pkg.sv
`include "i2c_consts.svh"

package i2c_bus_pkg;

    // single operations on the two lines
    typedef enum logic [2:0] {
        OP_START,
        OP_REPEATED_START,
        OP_STOP,
        OP_WRITE_BIT,
        OP_READ_BIT
    } bit_op_t;

    // quarter of one bit operation
    typedef logic [$clog2(`I2C_PHASES_PER_BIT)-1:0] phase_t;

endpackage

//--- src/i2c_txn_pkg.sv
`include "i2c_consts.svh"

package i2c_txn_pkg;

    // register transaction steps
    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_DEVICE_WRITE,
        S_REGISTER,
        S_DATA,
        S_RESTART,
        S_DEVICE_READ,
        S_READ_DATA,
        S_MASTER_NACK,
        S_STOP
    } txn_state_t;

    typedef logic [`I2C_BYTE_WIDTH-1:0] byte_t;

endpackage

//--- src/i2c_command_regs.sv
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_command_regs (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic                            cmd_valid,
    input  logic                            cmd_read,
    input  logic [`I2C_ADDR_WIDTH-1:0]      cmd_device_address,
    input  logic [`I2C_BYTE_WIDTH-1:0]      cmd_register_address,
    input  logic [`I2C_BYTE_WIDTH-1:0]      cmd_write_data,
    input  logic [`I2C_DIVIDER_WIDTH-1:0]   cmd_divider,
    input  logic                            txn_done,
    input  logic                            txn_ack_error,
    input  logic [`I2C_BYTE_WIDTH-1:0]      txn_read_data,
    output logic                            txn_start,
    output logic                            saved_read,
    output logic [`I2C_ADDR_WIDTH-1:0]      saved_device_address,
    output logic [`I2C_BYTE_WIDTH-1:0]      saved_register_address,
    output logic [`I2C_BYTE_WIDTH-1:0]      saved_write_data,
    output logic [`I2C_DIVIDER_WIDTH-1:0]   divider,
    output logic                            credit_return,
    output logic [`I2C_BYTE_WIDTH-1:0]      read_data,
    output logic                            ack_error
);

localparam int CREDIT_WIDTH = $clog2(`I2C_HOST_CREDITS + 1);

logic [CREDIT_WIDTH-1:0] in_flight;

// command held until the next one arrives
always_ff @(posedge clock) begin
    if (cmd_valid) begin
        saved_read              <= cmd_read;
        saved_device_address    <= cmd_device_address;
        saved_register_address  <= cmd_register_address;
        saved_write_data        <= cmd_write_data;
        divider                 <= cmd_divider;
    end
end

always_ff @(posedge clock) begin
    if (!reset_n) begin
        txn_start       <= 1'b0;
        credit_return   <= 1'b0;
        in_flight       <= '0;
        read_data       <= '0;
        ack_error       <= 1'b0;
    end
    else begin
        txn_start       <= cmd_valid;
        credit_return   <= txn_done;
        // slot freed at completion, credit follows a cycle later
        in_flight       <= in_flight + CREDIT_WIDTH'(cmd_valid) - CREDIT_WIDTH'(txn_done);
        if (txn_done) begin
            read_data   <= txn_read_data;
            ack_error   <= txn_ack_error;
        end
    end
end

// host must hold a credit for every command
assert property (@(posedge clock) disable iff (!reset_n)
    cmd_valid |-> (in_flight < `I2C_HOST_CREDITS));

endmodule

//--- src/i2c_bit_engine.sv
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_bit_engine
    import i2c_bus_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic [`I2C_DIVIDER_WIDTH-1:0]   divider,
    input  logic                            op_start,
    input  bit_op_t                         op,
    input  logic                            op_bit,
    input  logic                            serial_data_in,
    output logic                            op_done,
    output logic                            sampled_bit,
    output logic                            serial_clock_low,
    output logic                            serial_data_low
);

localparam phase_t LAST_PHASE = phase_t'(`I2C_PHASES_PER_BIT - 1);

logic                           busy;
logic                           tick;
phase_t                         phase;
logic [`I2C_DIVIDER_WIDTH-1:0]  tick_count;
bit_op_t                        active_op;

assign tick     = busy && (tick_count == divider);
assign op_done  = tick && (phase == LAST_PHASE);

////////////////////
// tick and phase counting

// divider restarts with each operation
always_ff @(posedge clock) begin
    if (!reset_n) begin
        busy        <= 1'b0;
        phase       <= '0;
        tick_count  <= '0;
    end
    else if (op_start) begin
        busy        <= 1'b1;
        phase       <= '0;
        tick_count  <= '0;
    end
    else if (tick) begin
        tick_count  <= '0;
        phase       <= phase + 1'b1;
        if (phase == LAST_PHASE) begin
            busy    <= 1'b0;
        end
    end
    else if (busy) begin
        tick_count  <= tick_count + 1'b1;
    end
end

always_ff @(posedge clock) begin
    if (op_start) begin
        active_op   <= op;
    end
    // sampled just before scl falls
    if (tick && phase == phase_t'(2)) begin
        sampled_bit <= serial_data_in;
    end
end

////////////////////
// line control

always_ff @(posedge clock) begin
    if (!reset_n) begin
        serial_clock_low    <= 1'b0;
        serial_data_low     <= 1'b0;
    end
    else if (op_start) begin
        // sda moves only while scl is low
        case (op)
            OP_WRITE_BIT:       serial_data_low <= !op_bit;
            OP_STOP:            serial_data_low <= 1'b1;
            OP_START:           serial_data_low <= serial_data_low;
            default:            serial_data_low <= 1'b0;
        endcase
    end
    else if (tick) begin
        case (active_op)
            OP_START: begin
                if (phase == phase_t'(1)) begin
                    serial_data_low <= 1'b1;
                end
                if (phase == LAST_PHASE) begin
                    serial_clock_low <= 1'b1;
                end
            end
            OP_REPEATED_START: begin
                if (phase == phase_t'(1)) begin
                    serial_clock_low <= 1'b0;
                end
                if (phase == phase_t'(2)) begin
                    serial_data_low <= 1'b1;
                end
                if (phase == LAST_PHASE) begin
                    serial_clock_low <= 1'b1;
                end
            end
            OP_STOP: begin
                if (phase == phase_t'(0)) begin
                    serial_clock_low <= 1'b0;
                end
                // sda rises with scl high
                if (phase == phase_t'(2)) begin
                    serial_data_low <= 1'b0;
                end
            end
            default: begin
                // data bit, scl high for two phases
                if (phase == phase_t'(0)) begin
                    serial_clock_low <= 1'b0;
                end
                if (phase == phase_t'(2)) begin
                    serial_clock_low <= 1'b1;
                end
            end
        endcase
    end
end

assert property (@(posedge clock) disable iff (!reset_n) op_start |-> !busy);

endmodule

//--- src/i2c_byte_sequencer.sv
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_byte_sequencer
    import i2c_bus_pkg::*;
    import i2c_txn_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic                        txn_start,
    input  logic                        saved_read,
    input  logic [`I2C_ADDR_WIDTH-1:0]  saved_device_address,
    input  logic [`I2C_BYTE_WIDTH-1:0]  saved_register_address,
    input  logic [`I2C_BYTE_WIDTH-1:0]  saved_write_data,
    input  logic                        op_done,
    input  logic                        sampled_bit,
    output logic                        op_start,
    output bit_op_t                     op,
    output logic                        op_bit,
    output logic                        txn_done,
    output logic                        txn_ack_error,
    output byte_t                       txn_read_data
);

localparam int MSB          = `I2C_BYTE_WIDTH - 1;
localparam int COUNT_WIDTH  = $clog2(`I2C_BYTE_WIDTH + 1);
localparam logic [COUNT_WIDTH-1:0] LAST_BIT = COUNT_WIDTH'(`I2C_BYTE_WIDTH - 1);
localparam logic [COUNT_WIDTH-1:0] ACK_SLOT = COUNT_WIDTH'(`I2C_BYTE_WIDTH);

txn_state_t             state;
byte_t                  shift_reg;
byte_t                  load_byte;
logic [COUNT_WIDTH-1:0] bit_count;
logic                   pending;

// byte that follows the current step
always_comb begin
    case (state)
        S_START:        load_byte = {saved_device_address, 1'b0};
        S_DEVICE_WRITE: load_byte = saved_register_address;
        S_REGISTER:     load_byte = saved_write_data;
        default:        load_byte = {saved_device_address, 1'b1};
    endcase
end

always_ff @(posedge clock) begin
    if (!reset_n) begin
        state           <= S_IDLE;
        op_start        <= 1'b0;
        txn_done        <= 1'b0;
        txn_ack_error   <= 1'b0;
        txn_read_data   <= '0;
        pending         <= 1'b0;
    end
    else begin
        op_start    <= 1'b0;
        txn_done    <= 1'b0;
        if (op_start) begin
            pending <= 1'b1;
        end
        else if (op_done) begin
            pending <= 1'b0;
        end

        case (state)
            S_IDLE: begin
                if (txn_start) begin
                    txn_ack_error   <= 1'b0;
                    state           <= S_START;
                    op              <= OP_START;
                    op_start        <= 1'b1;
                end
            end
            S_START, S_RESTART: begin
                if (op_done) begin
                    state       <= (state == S_START) ? S_DEVICE_WRITE : S_DEVICE_READ;
                    bit_count   <= '0;
                    op          <= OP_WRITE_BIT;
                    op_bit      <= load_byte[MSB];
                    shift_reg   <= load_byte << 1;
                    op_start    <= 1'b1;
                end
            end
            S_DEVICE_WRITE, S_REGISTER, S_DATA, S_DEVICE_READ: begin
                if (op_done) begin
                    op_start <= 1'b1;
                    if (bit_count < LAST_BIT) begin
                        bit_count   <= bit_count + 1'b1;
                        op          <= OP_WRITE_BIT;
                        op_bit      <= shift_reg[MSB];
                        shift_reg   <= shift_reg << 1;
                    end
                    else if (bit_count == LAST_BIT) begin
                        bit_count   <= ACK_SLOT;
                        op          <= OP_READ_BIT;
                    end
                    else if (sampled_bit) begin
                        // no acknowledge from the slave
                        txn_ack_error   <= 1'b1;
                        state           <= S_STOP;
                        op              <= OP_STOP;
                    end
                    else begin
                        bit_count   <= '0;
                        op          <= OP_WRITE_BIT;
                        op_bit      <= load_byte[MSB];
                        shift_reg   <= load_byte << 1;
                        case (state)
                            S_DEVICE_WRITE: state <= S_REGISTER;
                            S_REGISTER: begin
                                if (saved_read) begin
                                    state   <= S_RESTART;
                                    op      <= OP_REPEATED_START;
                                end
                                else begin
                                    state   <= S_DATA;
                                end
                            end
                            S_DATA: begin
                                state   <= S_STOP;
                                op      <= OP_STOP;
                            end
                            default: begin
                                state   <= S_READ_DATA;
                                op      <= OP_READ_BIT;
                            end
                        endcase
                    end
                end
            end
            S_READ_DATA: begin
                if (op_done) begin
                    op_start    <= 1'b1;
                    shift_reg   <= {shift_reg[MSB-1:0], sampled_bit};
                    if (bit_count == LAST_BIT) begin
                        txn_read_data   <= {shift_reg[MSB-1:0], sampled_bit};
                        state           <= S_MASTER_NACK;
                        op              <= OP_WRITE_BIT;
                        op_bit          <= 1'b1;
                    end
                    else begin
                        bit_count   <= bit_count + 1'b1;
                        op          <= OP_READ_BIT;
                    end
                end
            end
            S_MASTER_NACK: begin
                if (op_done) begin
                    state       <= S_STOP;
                    op          <= OP_STOP;
                    op_start    <= 1'b1;
                end
            end
            S_STOP: begin
                if (op_done) begin
                    state       <= S_IDLE;
                    txn_done    <= 1'b1;
                end
            end
            default: state <= S_IDLE;
        endcase
    end
end

// one operation in flight at a time
assert property (@(posedge clock) disable iff (!reset_n) op_start |-> !pending);

// a busy state always has an operation issued or in flight
assert property (@(posedge clock) disable iff (!reset_n)
    (state != S_IDLE) |-> (op_start || pending));

endmodule

//--- src/i2c_master_top.sv
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_master_top (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic                            cmd_valid,
    input  logic                            cmd_read,
    input  logic [`I2C_ADDR_WIDTH-1:0]      cmd_device_address,
    input  logic [`I2C_BYTE_WIDTH-1:0]      cmd_register_address,
    input  logic [`I2C_BYTE_WIDTH-1:0]      cmd_write_data,
    input  logic [`I2C_DIVIDER_WIDTH-1:0]   cmd_divider,
    output logic                            credit_return,
    output logic [`I2C_BYTE_WIDTH-1:0]      read_data,
    output logic                            ack_error,
    inout  wire                             serial_clock,
    inout  wire                             serial_data
);

logic                           txn_start;
logic                           saved_read;
logic [`I2C_ADDR_WIDTH-1:0]     saved_device_address;
logic [`I2C_BYTE_WIDTH-1:0]     saved_register_address;
logic [`I2C_BYTE_WIDTH-1:0]     saved_write_data;
logic [`I2C_DIVIDER_WIDTH-1:0]  divider;
logic                           txn_done;
logic                           txn_ack_error;
logic [`I2C_BYTE_WIDTH-1:0]     txn_read_data;
logic                           op_start;
i2c_bus_pkg::bit_op_t           op;
logic                           op_bit;
logic                           op_done;
logic                           sampled_bit;
logic                           serial_clock_low;
logic                           serial_data_low;

// open drain, pulled up outside
assign serial_clock = serial_clock_low ? 1'b0 : 1'bz;
assign serial_data  = serial_data_low  ? 1'b0 : 1'bz;

i2c_command_regs command_regs_i (
    .clock                  (clock),
    .reset_n                (reset_n),
    .cmd_valid              (cmd_valid),
    .cmd_read               (cmd_read),
    .cmd_device_address     (cmd_device_address),
    .cmd_register_address   (cmd_register_address),
    .cmd_write_data         (cmd_write_data),
    .cmd_divider            (cmd_divider),
    .txn_done               (txn_done),
    .txn_ack_error          (txn_ack_error),
    .txn_read_data          (txn_read_data),
    .txn_start              (txn_start),
    .saved_read             (saved_read),
    .saved_device_address   (saved_device_address),
    .saved_register_address (saved_register_address),
    .saved_write_data       (saved_write_data),
    .divider                (divider),
    .credit_return          (credit_return),
    .read_data              (read_data),
    .ack_error              (ack_error)
);

i2c_byte_sequencer byte_sequencer_i (
    .clock                  (clock),
    .reset_n                (reset_n),
    .txn_start              (txn_start),
    .saved_read             (saved_read),
    .saved_device_address   (saved_device_address),
    .saved_register_address (saved_register_address),
    .saved_write_data       (saved_write_data),
    .op_done                (op_done),
    .sampled_bit            (sampled_bit),
    .op_start               (op_start),
    .op                     (op),
    .op_bit                 (op_bit),
    .txn_done               (txn_done),
    .txn_ack_error          (txn_ack_error),
    .txn_read_data          (txn_read_data)
);

i2c_bit_engine bit_engine_i (
    .clock                  (clock),
    .reset_n                (reset_n),
    .divider                (divider),
    .op_start               (op_start),
    .op                     (op),
    .op_bit                 (op_bit),
    .serial_data_in         (serial_data),
    .op_done                (op_done),
    .sampled_bit            (sampled_bit),
    .serial_clock_low       (serial_clock_low),
    .serial_data_low        (serial_data_low)
);

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
end

// reset held over the first ten edges
initial begin
    reset_n = 1'b0;
    repeat (10) @(posedge clock);
    #2 reset_n = 1'b1;
end

endmodule

//--- testbench/i2c_slave_model.sv
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_slave_model (
    input  wire                             serial_clock,
    inout  wire                             serial_data,
    input  logic [`I2C_ADDR_WIDTH-1:0]      own_address,
    input  logic [`I2C_BYTE_WIDTH-1:0]      read_byte,
    output logic [`I2C_BYTE_WIDTH-1:0]      written_register,
    output logic [`I2C_BYTE_WIDTH-1:0]      written_data,
    output int                              write_count
);

localparam int BITS = `I2C_BYTE_WIDTH;

logic                       sda_low;
logic                       selected;
logic                       reading;
logic                       master_nack;
logic [BITS-1:0]            shift_in;
logic [BITS-1:0]            shift_out;
logic [BITS-1:0]            register_pointer;
int                         bit_count;
int                         byte_index;

assign serial_data = sda_low ? 1'b0 : 1'bz;

initial begin
    sda_low         = 1'b0;
    selected        = 1'b0;
    reading         = 1'b0;
    master_nack     = 1'b1;
    bit_count       = 0;
    byte_index      = 0;
    write_count     = 0;
end

////////////////////
// start and stop

always @(negedge serial_data) begin
    if (serial_clock === 1'b1) begin
        bit_count   = 0;
        byte_index  = 0;
        selected    = 1'b0;
        reading     = 1'b0;
        sda_low     = 1'b0;
    end
end

always @(posedge serial_data) begin
    if (serial_clock === 1'b1) begin
        bit_count   = 0;
        selected    = 1'b0;
        sda_low     = 1'b0;
    end
end

////////////////////
// bit transfer

always @(posedge serial_clock) begin
    bit_count++;
    if (bit_count <= BITS) begin
        shift_in = {shift_in[BITS-2:0], serial_data};
    end
    else begin
        master_nack = serial_data;
    end
end

// sda only changes while scl is low
always @(negedge serial_clock) begin
    if (bit_count == BITS) begin
        sda_low = 1'b0;
        if (byte_index == 0) begin
            if (shift_in[BITS-1:1] == own_address) begin
                selected    = 1'b1;
                reading     = shift_in[0];
                sda_low     = 1'b1;
            end
        end
        else if (selected && !reading) begin
            sda_low = 1'b1;
            if (byte_index == 1) begin
                register_pointer = shift_in;
            end
            else begin
                written_register    = register_pointer;
                written_data        = shift_in;
                write_count++;
            end
        end
    end
    else if (bit_count == BITS + 1) begin
        bit_count   = 0;
        byte_index++;
        sda_low     = 1'b0;
        shift_out   = read_byte;
        // first read byte, or the master acked the last one
        if (selected && reading && (byte_index == 1 || !master_nack)) begin
            sda_low = !shift_out[BITS-1];
        end
    end
    else if (bit_count > 0 && selected && reading && byte_index > 0) begin
        sda_low = !shift_out[BITS-1-bit_count];
    end
end

endmodule

//--- testbench/tb_i2c_master.sv
`timescale 1ns/1ps
`include "i2c_consts.svh"

module tb_i2c_master;

localparam int DRIVE_DELAY  = 2;
localparam int IDLE_GAP     = 4;
localparam int READ_OPS     = 39;

logic                           clock;
logic                           reset_n;
logic                           cmd_valid;
logic                           cmd_read;
logic [`I2C_ADDR_WIDTH-1:0]     cmd_device_address;
logic [`I2C_BYTE_WIDTH-1:0]     cmd_register_address;
logic [`I2C_BYTE_WIDTH-1:0]     cmd_write_data;
logic [`I2C_DIVIDER_WIDTH-1:0]  cmd_divider;
logic                           credit_return;
logic [`I2C_BYTE_WIDTH-1:0]     read_data;
logic                           ack_error;
wire                            serial_clock;
wire                            serial_data;

logic [`I2C_ADDR_WIDTH-1:0]     slave_address;
logic [`I2C_BYTE_WIDTH-1:0]     slave_read_byte;
logic [`I2C_BYTE_WIDTH-1:0]     written_register;
logic [`I2C_BYTE_WIDTH-1:0]     written_data;
int                             write_count;

// one entry per line of the tests file
string                          name_q[$];
logic                           read_q[$];
logic [`I2C_ADDR_WIDTH-1:0]     device_q[$];
logic [`I2C_ADDR_WIDTH-1:0]     slave_q[$];
logic [`I2C_BYTE_WIDTH-1:0]     register_q[$];
logic [`I2C_BYTE_WIDTH-1:0]     wdata_q[$];
logic [`I2C_BYTE_WIDTH-1:0]     rbyte_q[$];
int                             divider_q[$];
logic                           exp_ack_q[$];
logic [`I2C_BYTE_WIDTH-1:0]     exp_rdata_q[$];

string  current_test = "setup";
int     credits;
int     cycle_count = 0;
int     cycle_limit = 0;
int     expected_high = 0;
int     value_errors = 0;
int     other_errors = 0;
int     high_count = 0;
logic   scl_prev = 1'b1;
logic   scl_armed = 1'b0;

pullup (serial_clock);
pullup (serial_data);

tb_clock_gen clock_gen_i (
    .clock      (clock),
    .reset_n    (reset_n)
);

i2c_master_top i2c_master_top_i (
    .clock                  (clock),
    .reset_n                (reset_n),
    .cmd_valid              (cmd_valid),
    .cmd_read               (cmd_read),
    .cmd_device_address     (cmd_device_address),
    .cmd_register_address   (cmd_register_address),
    .cmd_write_data         (cmd_write_data),
    .cmd_divider            (cmd_divider),
    .credit_return          (credit_return),
    .read_data              (read_data),
    .ack_error              (ack_error),
    .serial_clock           (serial_clock),
    .serial_data            (serial_data)
);

i2c_slave_model slave_model_i (
    .serial_clock       (serial_clock),
    .serial_data        (serial_data),
    .own_address        (slave_address),
    .read_byte          (slave_read_byte),
    .written_register   (written_register),
    .written_data       (written_data),
    .write_count        (write_count)
);

task automatic report_mismatch(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    value_errors++;
    $display("** Error %s: %s expected %0h actual %0h", current_test, what, expected, actual);
endtask

task automatic report_failure(input string what);
    other_errors++;
    $display("%s: %s", current_test, what);
endtask

task automatic load_tests();
    int     fd;
    int     fields;
    string  line;
    string  name;
    int     rd, dev, slv, rg, wd, rb, dv, ea, er;
    fd = $fopen("testbench/i2c_tests.txt", "r");
    if (fd == 0) begin
        report_failure("the tests file could not be opened");
    end
    else begin
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%s %h %h %h %h %h %h %d %h %h",
                                 name, rd, dev, slv, rg, wd, rb, dv, ea, er);
                if (fields == 10) begin
                    name_q.push_back(name);
                    read_q.push_back(rd[0]);
                    device_q.push_back(dev[`I2C_ADDR_WIDTH-1:0]);
                    slave_q.push_back(slv[`I2C_ADDR_WIDTH-1:0]);
                    register_q.push_back(rg[`I2C_BYTE_WIDTH-1:0]);
                    wdata_q.push_back(wd[`I2C_BYTE_WIDTH-1:0]);
                    rbyte_q.push_back(rb[`I2C_BYTE_WIDTH-1:0]);
                    divider_q.push_back(dv);
                    exp_ack_q.push_back(ea[0]);
                    exp_rdata_q.push_back(er[`I2C_BYTE_WIDTH-1:0]);
                end
                else begin
                    report_failure("a line of the tests file has missing fields");
                end
            end
        end
        $fclose(fd);
    end
endtask

task automatic check_idle(input int cycles);
    repeat (cycles) begin
        @(posedge clock);
        // all credits are home, so any return is spurious
        assert (credit_return !== 1'b1 || credits < `I2C_HOST_CREDITS)
            else report_failure("credit_return arrived without an outstanding command");
        assert (serial_clock === 1'b1 && serial_data === 1'b1)
            else report_failure("a bus line was not released while idle");
    end
endtask

task automatic run_test(input int i);
    int writes_before;
    writes_before = write_count;
    #DRIVE_DELAY;
    current_test            = name_q[i];
    expected_high           = 2 * (divider_q[i] + 1);
    slave_address           = slave_q[i];
    slave_read_byte         = rbyte_q[i];
    cmd_valid               = 1'b1;
    cmd_read                = read_q[i];
    cmd_device_address      = device_q[i];
    cmd_register_address    = register_q[i];
    cmd_write_data          = wdata_q[i];
    cmd_divider             = divider_q[i][`I2C_DIVIDER_WIDTH-1:0];
    credits--;
    @(posedge clock);
    #DRIVE_DELAY;
    cmd_valid = 1'b0;
    while (credit_return !== 1'b1) @(posedge clock);
    credits++;

    assert (ack_error === exp_ack_q[i])
        else report_mismatch("ack_error", exp_ack_q[i], ack_error);
    if (read_q[i] && !exp_ack_q[i]) begin
        assert (read_data === exp_rdata_q[i])
            else report_mismatch("read_data", exp_rdata_q[i], read_data);
    end
    if (!read_q[i] && !exp_ack_q[i]) begin
        assert (write_count == writes_before + 1)
            else report_mismatch("slave write count", writes_before + 1, write_count);
        assert (written_register === register_q[i])
            else report_mismatch("slave register", register_q[i], written_register);
        assert (written_data === wdata_q[i])
            else report_mismatch("slave data", wdata_q[i], written_data);
    end
    else begin
        assert (write_count == writes_before)
            else report_mismatch("slave write count", writes_before, write_count);
    end
    check_idle(IDLE_GAP);
endtask

////////////////////
// watchdog

always @(posedge clock) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors + 1);
        $display("Simulation finished: FAIL");
        $finish;
    end
end

// scl high time of every pulse inside a transaction
always @(posedge clock) begin
    if (reset_n !== 1'b1 || credit_return === 1'b1) begin
        scl_armed   = 1'b0;
        scl_prev    = 1'b1;
    end
    else if (serial_clock === 1'b1) begin
        if (scl_prev === 1'b0) begin
            scl_armed   = 1'b1;
            high_count  = 0;
        end
        high_count++;
        scl_prev = 1'b1;
    end
    else begin
        if (scl_prev === 1'b1 && scl_armed) begin
            assert (high_count == expected_high)
                else report_mismatch("scl high cycles", expected_high, high_count);
        end
        scl_armed   = 1'b0;
        scl_prev    = 1'b0;
    end
end

////////////////////
// main sequence

initial begin
    cmd_valid               = 1'b0;
    cmd_read                = 1'b0;
    cmd_device_address      = '0;
    cmd_register_address    = '0;
    cmd_write_data          = '0;
    cmd_divider             = '0;
    slave_address           = '0;
    slave_read_byte         = '0;
    credits                 = `I2C_HOST_CREDITS;

    load_tests();
    if (name_q.size() == 0) begin
        report_failure("no tests were loaded");
    end
    cycle_limit = 100;
    foreach (divider_q[i]) begin
        cycle_limit += READ_OPS * `I2C_PHASES_PER_BIT * (divider_q[i] + 1) + 50;
    end

    wait (reset_n === 1'b1);
    current_test = "idle_after_reset";
    check_idle(20);

    foreach (name_q[i]) begin
        run_test(i);
    end

    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
        $display("Simulation finished: PASS");
    end
    else begin
        $display("Simulation finished: FAIL");
    end
    $finish;
end

endmodule

//--- build.f
+incdir+src
src/i2c_bus_pkg.sv
src/i2c_txn_pkg.sv
src/i2c_command_regs.sv
src/i2c_bit_engine.sv
src/i2c_byte_sequencer.sv
src/i2c_master_top.sv
testbench/tb_clock_gen.sv
testbench/i2c_slave_model.sv
testbench/tb_i2c_master.sv

//--- testbench/i2c_tests.txt
# name read device slave_address register write_data read_byte divider ack_error read_data
# every field is hex except the divider, which is decimal
write_basic  0 50 50 10 a5 00 3 0 00
read_basic   1 50 50 10 00 3c 3 0 3c
write_fast   0 2a 2a 7f 01 00 0 0 00
read_fast    1 2a 2a 80 00 c3 0 0 c3
write_slow   0 7f 7f 00 ff 00 9 0 00
read_slow    1 01 01 55 00 81 9 0 81
write_nack   0 51 50 20 ff 00 2 1 00
read_nack    1 11 22 04 00 99 1 1 00
write_after  0 50 50 33 5a 00 2 0 00
